// File: logic/la_pkg.sv
`default_nettype none

package la_pkg;

    localparam int SAMPLE_W     = 8;                 // probe pins
    localparam int ADDR_W       = 8;
    localparam int DEPTH        = 256;               // sample memory entries
    localparam int WPTR_W       = 16;                // reported pointer width
    localparam int CLKS_PER_BIT = 8;                 // scaled down baud divider
    localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);
    localparam int POST_SCALE   = 16;                // post byte multiplier
    localparam int POST_W       = 12;

    // command fields, mask arrives first so it sits in the low byte
    typedef struct packed {
        logic [7:0] post;
        logic [7:0] prescale;
        logic [7:0] pol;
        logic [7:0] mask;
    } la_cmd_fields_t;

    typedef union packed {
        logic [3:0][7:0] bytes;                      // filled in arrival order
        la_cmd_fields_t  f;                          // decoded fields
    } la_cmd_u;

    typedef enum logic [3:0] {
        IDLE,
        RECV,
        ARM,
        WAIT_DONE,
        SEND_WPTR_LO,
        SEND_WPTR_HI,
        READ_MEM,
        SEND_BYTE,
        WAIT_TX
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: logic/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx_i,
    output logic [7:0] byte_o,
    output logic       valid_o
);

    logic [1:0]                   rx_sync;       // two-flop synchronizer
    logic                         rx_prev;       // for start edge detect
    logic                         busy;
    logic [la_pkg::BIT_CNT_W-1:0] cnt;           // clocks to next sample point
    logic [3:0]                   bit_idx;       // 0 start, 1..8 data, 9 stop
    logic [7:0]                   shreg;
    logic                         sample_pt;

    assign sample_pt = busy && (cnt == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_sync <= 2'b11;                    // line idles high
            rx_prev <= 1'b1;
            busy    <= 1'b0;
            cnt     <= '0;
            bit_idx <= '0;
            valid_o <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[0], rx_i};
            rx_prev <= rx_sync[1];
            valid_o <= 1'b0;
            if (!busy) begin
                if (rx_prev && !rx_sync[1]) begin
                    busy    <= 1'b1;
                    cnt     <= la_pkg::BIT_CNT_W'(la_pkg::CLKS_PER_BIT / 2 - 1); // to mid-bit
                    bit_idx <= '0;
                end
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end else begin
                cnt     <= la_pkg::BIT_CNT_W'(la_pkg::CLKS_PER_BIT - 1);
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == 4'd0 && rx_sync[1]) begin
                    busy <= 1'b0;                // glitch, not a start bit
                end else if (bit_idx == 4'd9) begin
                    busy    <= 1'b0;
                    valid_o <= rx_sync[1];       // framing error drops the byte
                end
            end
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clk) begin
        if (sample_pt && bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
            shreg <= {rx_sync[1], shreg[7:1]};
        end
    end

    assign byte_o = shreg;

endmodule

`default_nettype wire

// File: logic/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start_i,
    input  logic [7:0] byte_i,
    output logic       tx_o,
    output logic       busy_o
);

    logic [9:0]                   frame;         // stop, data, start
    logic [la_pkg::BIT_CNT_W-1:0] cnt;
    logic [3:0]                   bits_left;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frame     <= '1;                     // idle line high
            busy_o    <= 1'b0;
            cnt       <= '0;
            bits_left <= '0;
        end else if (!busy_o) begin
            if (start_i) begin
                frame     <= {1'b1, byte_i, 1'b0};
                busy_o    <= 1'b1;
                cnt       <= la_pkg::BIT_CNT_W'(la_pkg::CLKS_PER_BIT - 1);
                bits_left <= 4'd9;
            end
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end else if (bits_left == 4'd0) begin
            busy_o <= 1'b0;                      // stop bit finished
        end else begin
            frame     <= {1'b1, frame[9:1]};
            bits_left <= bits_left - 1'b1;
            cnt       <= la_pkg::BIT_CNT_W'(la_pkg::CLKS_PER_BIT - 1);
        end
    end

    assign tx_o = frame[0];

    // a start during a frame would be silently lost
    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        start_i |-> !busy_o);

endmodule

`default_nettype wire

// File: logic/sample_ram.sv
`timescale 1ns/1ps
`default_nettype none

module sample_ram (
    input  logic                      clk,
    input  logic                      wr_en_i,
    input  logic [la_pkg::ADDR_W-1:0] wr_addr_i,
    input  logic [7:0]                wr_data_i,
    input  logic [la_pkg::ADDR_W-1:0] rd_addr_i,
    output logic [7:0]                rd_data_o
);

    logic [7:0] mem [la_pkg::DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // one cycle read latency, like a block ram
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

`default_nettype wire

// File: logic/capture_timer.sv
`timescale 1ns/1ps
`default_nettype none

module capture_timer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      arm_i,
    input  logic [7:0]                mask_i,
    input  logic [7:0]                pol_i,
    input  logic [7:0]                prescale_i,
    input  logic [7:0]                post_i,
    input  logic [7:0]                probe_i,
    output logic                      capturing_o,
    output logic                      triggered_o,
    output logic                      done_o,
    output logic                      wr_en_o,
    output logic [la_pkg::ADDR_W-1:0] wr_addr_o,
    output logic [7:0]                wr_data_o,
    output logic [la_pkg::WPTR_W-1:0] wptr_o
);

    logic [7:0]                probe_prev;       // last clock's probe value
    logic [7:0]                pre_cnt;
    logic [la_pkg::POST_W-1:0] post_cnt;         // samples left after trigger
    logic [la_pkg::ADDR_W-1:0] wptr;
    logic                      tick;
    logic                      trig_event;

    // a masked pin changed and a masked pin matches its polarity
    assign trig_event = (|((probe_i ^ probe_prev) & mask_i)) && (|(~(probe_i ^ pol_i) & mask_i));
    assign tick       = capturing_o && (pre_cnt == prescale_i);

    always_ff @(posedge clk) begin
        probe_prev <= probe_i;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            capturing_o <= 1'b0;
            triggered_o <= 1'b0;
            pre_cnt     <= '0;
            post_cnt    <= '0;
            wptr        <= '0;
        end else if (arm_i) begin
            capturing_o <= 1'b1;
            triggered_o <= 1'b0;
            pre_cnt     <= '0;
            post_cnt    <= la_pkg::POST_W'(post_i * la_pkg::POST_SCALE);
            wptr        <= '0;
        end else if (capturing_o) begin
            if (trig_event) begin
                triggered_o <= 1'b1;             // sticky until next arm
            end
            if (tick) begin
                pre_cnt <= '0;
                wptr    <= wptr + 1'b1;          // wraps at DEPTH
                if (triggered_o) begin
                    post_cnt <= post_cnt - 1'b1;
                end
                if (done_o) begin
                    capturing_o <= 1'b0;
                end
            end else begin
                pre_cnt <= pre_cnt + 1'b1;
            end
        end
    end

    assign done_o    = tick && triggered_o && (post_cnt == la_pkg::POST_W'(1)); // last sample
    assign wr_en_o   = tick;
    assign wr_addr_o = wptr;
    assign wr_data_o = probe_i;
    assign wptr_o    = la_pkg::WPTR_W'(wptr);    // oldest sample once done

    a_done_ends_capture: assert property (@(posedge clk) disable iff (!rst_n)
        done_o |-> capturing_o ##1 !capturing_o);

    a_wr_in_capture: assert property (@(posedge clk) disable iff (!rst_n)
        !capturing_o && !arm_i |=> !wr_en_o);

endmodule

`default_nettype wire

// File: logic/la_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module la_ctrl_fsm (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      rx_valid_i,
    input  logic [7:0]                rx_byte_i,
    input  logic                      tx_busy_i,
    input  logic                      capturing_i,
    input  logic                      triggered_i,
    input  logic                      done_i,
    input  logic [la_pkg::WPTR_W-1:0] wptr_i,
    input  logic [7:0]                rd_data_i,
    output logic                      tx_start_o,
    output logic [7:0]                tx_byte_o,
    output logic                      arm_o,
    output logic [7:0]                mask_o,
    output logic [7:0]                pol_o,
    output logic [7:0]                prescale_o,
    output logic [7:0]                post_o,
    output logic [la_pkg::ADDR_W-1:0] rd_addr_o,
    output logic [3:0]                led_o
);

    la_pkg::ctrl_state_e state;
    la_pkg::ctrl_state_e ret_state;              // where WAIT_TX goes next
    la_pkg::la_cmd_u     cmd;
    logic [1:0]          byte_cnt;
    logic                dumping;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= la_pkg::IDLE;
            ret_state  <= la_pkg::IDLE;
            byte_cnt   <= '0;
            tx_start_o <= 1'b0;
            arm_o      <= 1'b0;
            rd_addr_o  <= '0;
        end else begin
            tx_start_o <= 1'b0;
            arm_o      <= 1'b0;
            case (state)
                la_pkg::IDLE: begin
                    if (rx_valid_i) begin
                        cmd.bytes[0] <= rx_byte_i;
                        byte_cnt     <= 2'd1;
                        state        <= la_pkg::RECV;
                    end
                end
                la_pkg::RECV: begin
                    if (rx_valid_i) begin
                        cmd.bytes[byte_cnt] <= rx_byte_i;
                        byte_cnt            <= byte_cnt + 1'b1;
                        if (byte_cnt == 2'd3) begin
                            arm_o <= 1'b1;       // fields settle on this edge
                            state <= la_pkg::ARM;
                        end
                    end
                end
                la_pkg::ARM:       state <= la_pkg::WAIT_DONE;
                la_pkg::WAIT_DONE: if (done_i) state <= la_pkg::SEND_WPTR_LO;
                la_pkg::SEND_WPTR_LO: begin
                    tx_byte_o  <= wptr_i[7:0];
                    tx_start_o <= 1'b1;
                    ret_state  <= la_pkg::SEND_WPTR_HI;
                    state      <= la_pkg::WAIT_TX;
                end
                la_pkg::SEND_WPTR_HI: begin
                    tx_byte_o  <= wptr_i[15:8];
                    tx_start_o <= 1'b1;
                    rd_addr_o  <= '0;            // dump from address 0
                    ret_state  <= la_pkg::READ_MEM;
                    state      <= la_pkg::WAIT_TX;
                end
                la_pkg::READ_MEM:  state <= la_pkg::SEND_BYTE; // ram latency
                la_pkg::SEND_BYTE: begin
                    tx_byte_o  <= rd_data_i;
                    tx_start_o <= 1'b1;
                    rd_addr_o  <= rd_addr_o + 1'b1;
                    ret_state  <= (rd_addr_o == la_pkg::ADDR_W'(la_pkg::DEPTH - 1)) ?
                                  la_pkg::IDLE : la_pkg::READ_MEM;
                    state      <= la_pkg::WAIT_TX;
                end
                la_pkg::WAIT_TX: begin
                    // busy only rises the cycle after the start pulse
                    if (!tx_busy_i && !tx_start_o) state <= ret_state;
                end
                default: state <= la_pkg::IDLE;
            endcase
        end
    end

    assign mask_o     = cmd.f.mask;
    assign pol_o      = cmd.f.pol;
    assign prescale_o = cmd.f.prescale;
    assign post_o     = cmd.f.post;

    assign dumping = !(state inside {la_pkg::IDLE, la_pkg::RECV, la_pkg::ARM,
                                     la_pkg::WAIT_DONE});
    assign led_o   = {dumping, triggered_i && capturing_i, capturing_i,
                      state inside {la_pkg::IDLE, la_pkg::RECV}};

    a_arm_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        arm_o |-> state == la_pkg::ARM && !capturing_i ##1 capturing_i);

endmodule

`default_nettype wire

// File: logic/la_top.sv
`timescale 1ns/1ps
`default_nettype none

module la_top (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       uart_rx_i,
    output logic       uart_tx_o,
    input  logic [7:0] probe_i,
    output logic [3:0] led_o
);

    logic                      rx_valid;
    logic [7:0]                rx_byte;
    logic                      tx_start;
    logic [7:0]                tx_byte;
    logic                      tx_busy;
    logic                      arm;
    logic [7:0]                mask;
    logic [7:0]                pol;
    logic [7:0]                prescale;
    logic [7:0]                post;
    logic                      capturing;
    logic                      triggered;
    logic                      done;
    logic [la_pkg::WPTR_W-1:0] wptr;
    logic                      wr_en;
    logic [la_pkg::ADDR_W-1:0] wr_addr;
    logic [7:0]                wr_data;
    logic [la_pkg::ADDR_W-1:0] rd_addr;
    logic [7:0]                rd_data;

    uart_rx u_rx (.clk(clk), .rst_n(rst_n), .rx_i(uart_rx_i), .byte_o(rx_byte),
                  .valid_o(rx_valid));

    uart_tx u_tx (.clk(clk), .rst_n(rst_n), .start_i(tx_start), .byte_i(tx_byte),
                  .tx_o(uart_tx_o), .busy_o(tx_busy));

    la_ctrl_fsm u_ctrl (
        .clk(clk), .rst_n(rst_n),
        .rx_valid_i(rx_valid), .rx_byte_i(rx_byte), .tx_busy_i(tx_busy),
        .capturing_i(capturing), .triggered_i(triggered), .done_i(done),
        .wptr_i(wptr), .rd_data_i(rd_data),
        .tx_start_o(tx_start), .tx_byte_o(tx_byte), .arm_o(arm),
        .mask_o(mask), .pol_o(pol), .prescale_o(prescale), .post_o(post),
        .rd_addr_o(rd_addr), .led_o(led_o));

    capture_timer u_timer (
        .clk(clk), .rst_n(rst_n), .arm_i(arm),
        .mask_i(mask), .pol_i(pol), .prescale_i(prescale), .post_i(post),
        .probe_i(probe_i),
        .capturing_o(capturing), .triggered_o(triggered), .done_o(done),
        .wr_en_o(wr_en), .wr_addr_o(wr_addr), .wr_data_o(wr_data), .wptr_o(wptr));

    sample_ram u_ram (.clk(clk), .wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
                      .rd_addr_i(rd_addr), .rd_data_o(rd_data));

endmodule

`default_nettype wire

// File: verif/la_tb.sv
`timescale 1ns/1ps
`default_nettype none

module la_tb;

    localparam int NUM_CMDS  = 6;
    localparam int DEPTH     = la_pkg::DEPTH;
    localparam int BIT_CYC   = la_pkg::CLKS_PER_BIT;
    localparam int FRAME_CYC = 10 * BIT_CYC;
    localparam int QUIET_CYC = 16;                   // probes frozen while arming
    localparam int TRIG_WAIT = 2000;                 // allowance for a trigger to show up
    localparam int CMD_CYC   = 4 * FRAME_CYC + QUIET_CYC;
    localparam int CAPT_CYC  = TRIG_WAIT + 4 * la_pkg::POST_SCALE * 4;
    localparam int DUMP_CYC  = (DEPTH + 2) * (FRAME_CYC + 4) + 2 * FRAME_CYC;
    localparam int RUN_CYC   = 200 + NUM_CMDS * (CMD_CYC + CAPT_CYC + DUMP_CYC);
    localparam int HIST_LEN  = 2 * RUN_CYC;

    logic       clk;
    logic       rst_n;
    logic       uart_rx_i;
    logic       uart_tx_o;
    logic [7:0] probe_i;
    logic [3:0] led_o;

    logic [7:0] hist [HIST_LEN];                     // probe value at each rising edge
    int         cyc = 0;                             // rising edges so far
    logic [7:0] rx_q [$];                            // bytes decoded from uart_tx_o
    int         fall_q [$];                          // start bit edge of each byte
    logic       rx_active = 1'b0;
    logic       quiet;
    int         phase;                               // 0 idle, 1 capture, 2 dump
    int         quiet_end;
    logic       trig_seen = 1'b0;
    int         trig_cyc = 0;
    logic [7:0] cur_mask;
    logic [7:0] cur_pol;
    logic [7:0] cur_pre;
    logic [7:0] cur_post;
    logic [7:0] ordered [DEPTH];                     // dump reordered oldest first

    la_top uut (
        .clk(clk), .rst_n(rst_n), .uart_rx_i(uart_rx_i), .uart_tx_o(uart_tx_o),
        .probe_i(probe_i), .led_o(led_o));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // masked pin changed since last clock and a masked pin equals its polarity
    function automatic bit is_trigger(input int c);
        bit changed;
        bit matched;
        changed = 1'b0;
        matched = 1'b0;
        for (int p = 0; p < 8; p++) begin
            if (cur_mask[p] && hist[c][p] != hist[c - 1][p]) begin
                changed = 1'b1;
            end
            if (cur_mask[p] && hist[c][p] == cur_pol[p]) begin
                matched = 1'b1;
            end
        end
        return changed && matched;
    endfunction

    // newest samples must follow the probe history at a fixed spacing
    function automatic bit samples_match(input int last, input int step);
        int n;
        int start;
        n = (last - quiet_end) / step + 1;           // surely taken after arm
        if (n > DEPTH) begin
            n = DEPTH;
        end
        start = last - (n - 1) * step;
        for (int k = 0; k < n; k++) begin
            if (ordered[DEPTH - n + k] !== hist[start + k * step]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            uart_rx_i = frame[i];                    // lsb first after the start bit
            repeat (BIT_CYC) @(negedge clk);
        end
    endtask

    always @(posedge clk) begin
        if (cyc < HIST_LEN) begin
            hist[cyc] <= probe_i;
        end
        cyc <= cyc + 1;
    end

    initial begin : probe_drive
        int hold;
        probe_i = 8'h00;
        hold    = 1;
        forever begin
            @(negedge clk);
            if (!quiet) begin
                hold = hold - 1;
                if (hold == 0) begin
                    probe_i = 8'($urandom);
                    hold    = 1 + int'($urandom_range(3));
                end
            end
        end
    end

    initial begin : uart_receiver
        logic [7:0] data;
        int         fall;
        forever begin
            @(negedge clk);
            if (uart_tx_o === 1'b0) begin
                fall      = cyc - 1;
                rx_active = 1'b1;
                repeat (BIT_CYC / 2) @(negedge clk);
                if (uart_tx_o !== 1'b0) begin
                    report_failure("start bit from the DUT did not stay low");
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (BIT_CYC) @(negedge clk);
                    data[i] = uart_tx_o;
                end
                repeat (BIT_CYC) @(negedge clk);
                if (uart_tx_o !== 1'b1) begin
                    report_failure("stop bit from the DUT was low");
                end
                rx_q.push_back(data);
                fall_q.push_back(fall);
                rx_active = 1'b0;
            end
        end
    end

    always @(negedge clk) begin : led_monitor
        int last;
        int step;
        last = cyc - 1;
        step = int'(cur_pre) + 1;
        if (phase == 0) begin
            trig_seen = 1'b0;
        end else if (phase == 1 && last > quiet_end) begin
            if (!trig_seen && is_trigger(last)) begin
                trig_seen = 1'b1;
                trig_cyc  = last;
            end
            if (!trig_seen) begin
                check_value("led_o", 32'(led_o), 32'b0010);  // armed, no trigger yet
            end else if (last <= trig_cyc + (int'(cur_post) * la_pkg::POST_SCALE - 1) * step) begin
                check_value("led_o", 32'(led_o), 32'b0110);
            end
        end else if (phase == 2 && rx_active) begin
            check_value("led_o", 32'(led_o), 32'b1000);      // dumping
        end
    end

    task automatic run_command(input int n);
        logic [15:0] wptr_raw;
        int          base;
        int          wptr;
        int          step;
        int          end_cyc;
        int          after;
        int          exp_after;
        bit          found;
        base     = rx_q.size();
        cur_mask = 8'($urandom_range(255, 1));
        cur_pol  = 8'($urandom);
        cur_pre  = 8'($urandom_range(3));
        cur_post = 8'($urandom_range(4, 1));
        step     = int'(cur_pre) + 1;
        $display("command %0d: mask %h pol %h prescale %0d post %0d",
                 n, cur_mask, cur_pol, cur_pre, cur_post);
        quiet = 1'b1;
        @(negedge clk);
        send_byte(cur_mask);
        send_byte(cur_pol);
        send_byte(cur_pre);
        send_byte(cur_post);
        repeat (QUIET_CYC) @(negedge clk);
        quiet_end = cyc - 1;
        phase     = 1;
        quiet     = 1'b0;
        while (!rx_active) @(negedge clk);
        phase = 2;
        while (rx_q.size() < base + DEPTH + 2) @(negedge clk);
        repeat (FRAME_CYC) @(negedge clk);           // room for a stray extra byte
        check_value("dump byte count", 32'(rx_q.size() - base), 32'(DEPTH + 2));
        check_value("rx_active after dump", 32'(rx_active), 32'd0);

        wptr_raw = {rx_q[base + 1], rx_q[base]};     // low byte arrives first
        wptr     = int'(wptr_raw);
        check_value("wptr high byte", 32'(wptr_raw[15:8]), 32'd0);
        for (int k = 0; k < DEPTH; k++) begin
            ordered[k] = rx_q[base + 2 + (wptr + k) % DEPTH];
        end

        found   = 1'b0;
        end_cyc = 0;
        for (int e = fall_q[base] - 1; e >= fall_q[base] - 6; e--) begin
            if (!found && samples_match(e, step)) begin
                found   = 1'b1;
                end_cyc = e;
            end
        end
        if (!found) begin
            report_failure("dumped samples match no evenly spaced run of probe history");
        end
        if (!trig_seen || trig_cyc >= end_cyc) begin
            report_failure("capture ended without a trigger event before its last sample");
        end
        after = 0;
        for (int c = end_cyc; c > trig_cyc; c -= step) begin
            after++;
        end
        exp_after = int'(cur_post) * la_pkg::POST_SCALE;
        if (after < exp_after - 1 || after > exp_after + 1) begin
            check_value("samples after trigger", 32'(after), 32'(exp_after));
        end
        phase = 0;
    endtask

    initial begin : watchdog
        repeat (2 * RUN_CYC) @(posedge clk);
        report_failure("timeout, the run did not finish in the allowed number of cycles");
    end

    initial begin : main_flow
        void'($urandom(32'h4142_4388));
        rst_n     = 1'b0;
        uart_rx_i = 1'b1;                            // idle line
        quiet     = 1'b1;
        phase     = 0;
        quiet_end = 0;
        cur_mask  = 8'h00;
        cur_pol   = 8'h00;
        cur_pre   = 8'h00;
        cur_post  = 8'h00;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("uart_tx_o", 32'(uart_tx_o), 32'd1);
        check_value("led_o", 32'(led_o), 32'b0001);
        repeat (4 * FRAME_CYC) @(negedge clk);
        check_value("bytes before a command", 32'(rx_q.size()), 32'd0);
        for (int n = 0; n < NUM_CMDS; n++) begin
            run_command(n);                          // next one follows right after
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic_analyzer.f
logic/la_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/sample_ram.sv
logic/capture_timer.sv
logic/la_ctrl_fsm.sv
logic/la_top.sv
verif/la_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
LINTFLAGS = --lint-only -Wall --timing
TOP       = la_tb
FILELIST  = logic_analyzer.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
